/* design/chroma_modulator.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module chroma_modulator (
        input  logic                         clk_dot4x,
        input  logic                         rst_n,
        input  logic                         in_valid,
        input  logic [`LUMA_W-1:0]           luma,
        input  logic [`AMP_W-1:0]            amp,
        input  logic [`PHASE_W-1:0]          phase,
        input  video_pkg::pixel_kind_e       in_kind,
        input  palette_pkg::chip_model_e     chip,
        output logic                         out_valid,
        output logic [`LUMA_W-1:0]           out_luma,
        output logic signed [`CHROMA_W-1:0]  chroma,
        output video_pkg::pixel_kind_e       out_kind
);

        localparam logic [`PHASE_W-1:0]        STEP       = `SC_STEP;
        localparam logic [`PHASE_W-1:0]        BURST_NTSC = `BURST_PHASE_NTSC;
        localparam logic [`PHASE_W-1:0]        BURST_PAL  = `BURST_PHASE_PAL;
        localparam logic [`AMP_W-1:0]          AMP_BURST  = `BURST_AMP;
        localparam logic [`AMP_W-1:0]          NO_MOD     = `AMP_OFF;
        localparam logic signed [`CHROMA_W-1:0] PEAK      = `SINE_PEAK;
        // 4x subcarrier, one sample per quadrant
        localparam logic signed [`CHROMA_W-1:0] SINE_TAB [4] = '{'0, PEAK, '0, -PEAK};

        logic [`PHASE_W-1:0]         acc;          // free running subcarrier phase
        logic [`PHASE_W-1:0]         phase_sel;
        logic [`PHASE_W-1:0]         phase_sum;
        logic [`AMP_W-1:0]           amp_sel;
        logic signed [`CHROMA_W-1:0] sample;
        logic [`CHROMA_W-1:0]        mag;          // |sample| shifted
        logic signed [`CHROMA_W-1:0] chroma_n;

        always_comb begin
                if (in_kind == video_pkg::kind_burst) begin
                        // burst ignores palette, fixed reference hue
                        phase_sel = (chip == palette_pkg::chip_6569 ||
                                     chip == palette_pkg::chip_unused) ? BURST_PAL : BURST_NTSC;
                        amp_sel   = AMP_BURST;
                end else begin
                        phase_sel = phase;
                        amp_sel   = amp;
                end
                phase_sum = acc + phase_sel;                      // wraps mod one turn
                sample    = SINE_TAB[phase_sum[`PHASE_W-1 -: 2]]; // top bits pick quadrant
                // scale magnitude so both signs shrink alike
                mag       = (sample < 0) ? $unsigned(-sample) : $unsigned(sample);
                mag       = mag >> amp_sel;
                if (amp_sel == NO_MOD) begin
                        chroma_n = '0;                            // grey, no subcarrier
                end else begin
                        chroma_n = (sample < 0) ? -$signed(mag) : $signed(mag);
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n) begin
                        acc       <= '0;
                        out_valid <= 1'b0;
                end else begin
                        acc       <= acc + STEP;   // steps with or without a pixel
                        out_valid <= in_valid;
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (in_valid) begin
                        out_luma <= luma;
                        chroma   <= chroma_n;
                        out_kind <= in_kind;
                end
        end

endmodule

/* design/composite_encoder.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module composite_encoder (
        input  logic                         clk_dot4x,
        input  logic                         rst_n,
        input  logic                         pix_valid,   // one pixel per strobe
        input  palette_pkg::color_index_e    pix_index,
        input  video_pkg::pixel_kind_e       pix_kind,
        input  palette_pkg::chip_model_e     chip,        // quasi-static
        output logic                         out_valid,
        output logic [`LUMA_W-1:0]           luma_out,
        output logic signed [`CHROMA_W-1:0]  chroma_out,
        output logic [`COMP_W-1:0]           composite_out
);

        // stage 1 -> 2
        logic                        s1_valid;
        logic [`LUMA_W-1:0]          s1_luma;
        logic [`AMP_W-1:0]           s1_amp;
        logic [`PHASE_W-1:0]         s1_phase;
        video_pkg::pixel_kind_e      s1_kind;
        // stage 2 -> 3
        logic                        s2_valid;
        logic [`LUMA_W-1:0]          s2_luma;
        logic signed [`CHROMA_W-1:0] s2_chroma;
        video_pkg::pixel_kind_e      s2_kind;

        palette_lookup u_lookup (
                .clk_dot4x (clk_dot4x),
                .rst_n     (rst_n),
                .in_valid  (pix_valid),
                .index     (pix_index),
                .kind      (pix_kind),
                .chip      (chip),
                .out_valid (s1_valid),
                .luma      (s1_luma),
                .amp       (s1_amp),
                .phase     (s1_phase),
                .out_kind  (s1_kind)
        );

        chroma_modulator u_mod (
                .clk_dot4x (clk_dot4x),
                .rst_n     (rst_n),
                .in_valid  (s1_valid),
                .luma      (s1_luma),
                .amp       (s1_amp),
                .phase     (s1_phase),
                .in_kind   (s1_kind),
                .chip      (chip),        // burst hue follows chip
                .out_valid (s2_valid),
                .out_luma  (s2_luma),
                .chroma    (s2_chroma),
                .out_kind  (s2_kind)
        );

        video_mixer u_mix (
                .clk_dot4x     (clk_dot4x),
                .rst_n         (rst_n),
                .in_valid      (s2_valid),
                .luma          (s2_luma),
                .chroma        (s2_chroma),
                .kind          (s2_kind),
                .out_valid     (out_valid),
                .luma_out      (luma_out),
                .chroma_out    (chroma_out),
                .composite_out (composite_out)
        );

endmodule

/* design/palette_lookup.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module palette_lookup (
        input  logic                      clk_dot4x,
        input  logic                      rst_n,
        input  logic                      in_valid,
        input  palette_pkg::color_index_e index,
        input  video_pkg::pixel_kind_e    kind,
        input  palette_pkg::chip_model_e  chip,
        output logic                      out_valid,
        output logic [`LUMA_W-1:0]        luma,
        output logic [`AMP_W-1:0]         amp,
        output logic [`PHASE_W-1:0]       phase,
        output video_pkg::pixel_kind_e    out_kind
);

        localparam logic [`AMP_W-1:0] NO_MOD = `AMP_OFF;

        logic                 pal;      // pal phase table
        logic [`LUMA_W-1:0]   luma_n;
        logic [`AMP_W-1:0]    amp_n;
        logic [`PHASE_W-1:0]  phase_n;

        assign pal = (chip == palette_pkg::chip_6569) || (chip == palette_pkg::chip_unused);

        // luma, nine distinct levels
        always_comb begin
                case (index)
                palette_pkg::color_black:       luma_n = 6'b010011;  // lvl 0
                palette_pkg::color_white:       luma_n = 6'b111011;  // lvl 8
                palette_pkg::color_red:         luma_n = 6'b011111;  // lvl 2
                palette_pkg::color_cyan:        luma_n = 6'b101100;  // lvl 6
                palette_pkg::color_purple:      luma_n = 6'b100010;  // lvl 3
                palette_pkg::color_green:       luma_n = 6'b100111;  // lvl 5
                palette_pkg::color_blue:        luma_n = 6'b011100;  // lvl 1
                palette_pkg::color_yellow:      luma_n = 6'b110010;  // lvl 7
                palette_pkg::color_orange:      luma_n = 6'b100010;
                palette_pkg::color_brown:       luma_n = 6'b011100;
                palette_pkg::color_pink:        luma_n = 6'b100111;
                palette_pkg::color_dark_grey:   luma_n = 6'b011111;
                palette_pkg::color_grey:        luma_n = 6'b100110;  // lvl 4
                palette_pkg::color_light_green: luma_n = 6'b110010;
                palette_pkg::color_light_blue:  luma_n = 6'b100110;
                palette_pkg::color_light_grey:  luma_n = 6'b101100;
                endcase
        end

        // amplitude, 0 strongest, greys get no subcarrier
        always_comb begin
                case (index)
                palette_pkg::color_black:       amp_n = NO_MOD;
                palette_pkg::color_white:       amp_n = NO_MOD;
                palette_pkg::color_red:         amp_n = 3'd2;
                palette_pkg::color_cyan:        amp_n = 3'd2;
                palette_pkg::color_purple:      amp_n = 3'd1;
                palette_pkg::color_green:       amp_n = 3'd1;
                palette_pkg::color_blue:        amp_n = 3'd2;
                palette_pkg::color_yellow:      amp_n = 3'd0;   // most saturated
                palette_pkg::color_orange:      amp_n = 3'd0;
                palette_pkg::color_brown:       amp_n = 3'd2;
                palette_pkg::color_pink:        amp_n = 3'd2;
                palette_pkg::color_dark_grey:   amp_n = NO_MOD;
                palette_pkg::color_grey:        amp_n = NO_MOD;
                palette_pkg::color_light_green: amp_n = 3'd2;
                palette_pkg::color_light_blue:  amp_n = 3'd2;
                palette_pkg::color_light_grey:  amp_n = NO_MOD;
                endcase
        end

        // hue as phase offset, ntsc or pal column
        always_comb begin
                case (index)
                palette_pkg::color_red:         phase_n = pal ? 8'd80  : 8'd184;
                palette_pkg::color_cyan:        phase_n = pal ? 8'd208 : 8'd56;
                palette_pkg::color_purple:      phase_n = pal ? 8'd32  : 8'd136;
                palette_pkg::color_green:       phase_n = pal ? 8'd160 : 8'd8;
                palette_pkg::color_blue:        phase_n = pal ? 8'd0   : 8'd104;
                palette_pkg::color_yellow:      phase_n = pal ? 8'd128 : 8'd232;
                palette_pkg::color_orange:      phase_n = pal ? 8'd96  : 8'd200;
                palette_pkg::color_brown:       phase_n = pal ? 8'd112 : 8'd216;
                palette_pkg::color_pink:        phase_n = pal ? 8'd80  : 8'd184;  // red hue
                palette_pkg::color_light_green: phase_n = pal ? 8'd160 : 8'd8;
                palette_pkg::color_light_blue:  phase_n = pal ? 8'd0   : 8'd104;
                default:                        phase_n = '0;   // greys, phase unused
                endcase
        end

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                end
        end

        // payload only moves with a pixel
        always_ff @(posedge clk_dot4x) begin
                if (in_valid) begin
                        luma     <= luma_n;
                        amp      <= amp_n;
                        phase    <= phase_n;
                        out_kind <= kind;
                end
        end

endmodule

/* design/palette_pkg.sv */
package palette_pkg;

        // palette order as the chip numbers it
        typedef enum logic [3:0] {
                color_black       = 4'd0,
                color_white       = 4'd1,
                color_red         = 4'd2,
                color_cyan        = 4'd3,
                color_purple      = 4'd4,
                color_green       = 4'd5,
                color_blue        = 4'd6,
                color_yellow      = 4'd7,
                color_orange      = 4'd8,
                color_brown       = 4'd9,
                color_pink        = 4'd10,  // light red
                color_dark_grey   = 4'd11,
                color_grey        = 4'd12,
                color_light_green = 4'd13,
                color_light_blue  = 4'd14,
                color_light_grey  = 4'd15
        } color_index_e;

        // chip model, picks the phase table
        // ntsc parts share one table, pal part and the spare code the other
        typedef enum logic [1:0] {
                chip_6567r56a = 2'd0,   // early ntsc
                chip_6567r8   = 2'd1,   // later ntsc
                chip_6569     = 2'd2,   // pal
                chip_unused   = 2'd3    // treated as pal
        } chip_model_e;

endpackage

/* design/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// datapath widths
`define LUMA_W      6       // luma code, 0..63
`define AMP_W       3       // chroma amplitude code
`define PHASE_W     8       // 256 steps per full turn
`define CHROMA_W    6       // signed chroma sample
`define COMP_W      8       // unsigned composite sample

// amplitude code with no colour modulation
`define AMP_OFF     7

// sine table peak, fits CHROMA_W signed
`define SINE_PEAK   31

// subcarrier
`define SC_STEP     64      // quarter turn per dot4x clock
`define BURST_PHASE_NTSC 128
`define BURST_PHASE_PAL  96
`define BURST_AMP   2       // burst swing, same code as the mid colours

// fixed output levels
`define SYNC_LEVEL  0       // sync tip on luma and composite
`define BLANK_LEVEL 19      // blank and burst pedestal, black luma code

`endif

/* design/video_mixer.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module video_mixer (
        input  logic                         clk_dot4x,
        input  logic                         rst_n,
        input  logic                         in_valid,
        input  logic [`LUMA_W-1:0]           luma,
        input  logic signed [`CHROMA_W-1:0]  chroma,
        input  video_pkg::pixel_kind_e       kind,
        output logic                         out_valid,
        output logic [`LUMA_W-1:0]           luma_out,
        output logic signed [`CHROMA_W-1:0]  chroma_out,
        output logic [`COMP_W-1:0]           composite_out
);

        localparam logic [`LUMA_W-1:0]         LUMA_SYNC  = `SYNC_LEVEL;
        localparam logic [`LUMA_W-1:0]         LUMA_BLANK = `BLANK_LEVEL;
        localparam logic [`COMP_W-1:0]         COMP_SYNC  = `SYNC_LEVEL;
        localparam logic signed [`COMP_W+1:0]  COMP_MAX   = (1 << `COMP_W) - 1;

        logic [`LUMA_W-1:0]          base;      // pedestal or pixel luma
        logic signed [`CHROMA_W-1:0] chroma_sel;
        logic signed [`COMP_W+1:0]   sum;       // two guard bits
        logic [`COMP_W-1:0]          comp_n;

        always_comb begin
                case (kind)
                video_pkg::kind_active: base = luma;
                video_pkg::kind_sync:   base = LUMA_SYNC;
                default:                base = LUMA_BLANK;   // blank, burst
                endcase
                // subcarrier only on picture and burst
                chroma_sel = (kind == video_pkg::kind_active || kind == video_pkg::kind_burst) ?
                             chroma : '0;
                sum = $signed({{(`COMP_W + 2 - `LUMA_W){1'b0}}, base}) + chroma_sel;
                if (sum < 0)
                        comp_n = '0;                          // clamp low
                else if (sum > COMP_MAX)
                        comp_n = '1;                          // clamp high
                else
                        comp_n = sum[`COMP_W-1:0];
        end

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n) begin
                        out_valid     <= 1'b0;
                        luma_out      <= LUMA_SYNC;   // idle at sync tip
                        chroma_out    <= '0;
                        composite_out <= COMP_SYNC;
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                luma_out      <= base;
                                chroma_out    <= chroma_sel;
                                composite_out <= comp_n;
                        end
                end
        end

endmodule

/* design/video_pkg.sv */
package video_pkg;

        // what the raster timing wants on the wire for this dot
        // active takes the palette colour, the rest override it
        typedef enum logic [1:0] {
                kind_active = 2'd0,     // visible pixel
                kind_blank  = 2'd1,     // blanking pedestal
                kind_sync   = 2'd2,     // sync tip
                kind_burst  = 2'd3      // colour burst on blank pedestal
        } pixel_kind_e;

endpackage

/* files.f */
+incdir+design
design/palette_pkg.sv
design/video_pkg.sv
design/palette_lookup.sv
design/chroma_modulator.sv
design/video_mixer.sv
design/composite_encoder.sv
sim/composite_encoder_assert.sv
sim/composite_encoder_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
        --top-module composite_encoder_tb -f files.f -o composite_encoder_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/composite_encoder_sim +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
        echo "simulation ended with status $status"
        exit $status
fi
exit 0

/* sim/composite_encoder_assert.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module composite_encoder_assert (
        input logic                         clk_dot4x,
        input logic                         rst_n,
        input logic                         pix_valid,
        input palette_pkg::color_index_e    pix_index,
        input video_pkg::pixel_kind_e       pix_kind,
        input logic                         out_valid,
        input logic [`LUMA_W-1:0]           luma_out,
        input logic signed [`CHROMA_W-1:0]  chroma_out,
        input logic [`COMP_W-1:0]           composite_out
);

        // reference luma code per palette colour in index order
        localparam logic [`LUMA_W-1:0] LUMA_CODE [16] = '{
                6'd19, 6'd59, 6'd31, 6'd44, 6'd34, 6'd39, 6'd28, 6'd50,
                6'd34, 6'd28, 6'd39, 6'd31, 6'd38, 6'd50, 6'd38, 6'd44};
        // amplitude code per colour where 7 means no subcarrier
        localparam logic [`AMP_W-1:0] AMP_CODE [16] = '{
                3'd7, 3'd7, 3'd2, 3'd2, 3'd1, 3'd1, 3'd2, 3'd0,
                3'd0, 3'd2, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2, 3'd7};
        localparam logic [`AMP_W-1:0]  AMP_BURST  = `BURST_AMP;
        localparam logic [`LUMA_W-1:0] LUMA_BLANK = `BLANK_LEVEL;

        logic [2:0]  v_q;               // strobe history with bit 2 on out_valid
        logic [11:0] idx_q;             // three indexes with the oldest on top
        logic [5:0]  kind_q;
        logic [3:0]  idx3;              // colour now at the output
        logic [1:0]  kind3;
        logic        act;               // active pixel on the output
        logic        err_seen = 1'b0;   // sticky once any check fires

        // chroma magnitude is a zero crossing or the scaled peak
        function automatic logic mag_ok(input logic signed [`CHROMA_W-1:0] c,
                                        input logic [`AMP_W-1:0] amp);
                int m;
                m = (c < 0) ? -int'(c) : int'(c);
                return (m == 0) || (m == (`SINE_PEAK >> amp));
        endfunction

        // luma plus chroma clamped to the composite range
        function automatic logic [`COMP_W-1:0] comp_ref(input logic [`LUMA_W-1:0] l,
                                                         input logic signed [`CHROMA_W-1:0] c);
                int s;
                s = int'(l) + int'(c);
                return (s < 0) ? '0 : (s > (1 << `COMP_W) - 1) ? '1 : s[`COMP_W-1:0];
        endfunction

        task automatic flag_error(input string msg);
                err_seen <= 1'b1;
                $error("%s", msg);
        endtask

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n)
                        v_q <= '0;
                else
                        v_q <= {v_q[1:0], pix_valid};
                idx_q  <= {idx_q[7:0], pix_index};      // payload shifts in step with the strobe
                kind_q <= {kind_q[3:0], pix_kind};
        end

        assign idx3  = idx_q[11:8];
        assign kind3 = kind_q[5:4];
        assign act   = out_valid && kind3 == video_pkg::kind_active;

        // idle outputs sit at the sync tip
        a_reset: assert property (@(posedge clk_dot4x) !rst_n |=> !out_valid &&
                int'(luma_out) == `SYNC_LEVEL && chroma_out == '0 &&
                int'(composite_out) == `SYNC_LEVEL)
                else flag_error($sformatf("FAIL reset: expected 0 %0d 0 %0d, actual %0b %0d %0d %0d",
                        `SYNC_LEVEL, `SYNC_LEVEL, $sampled(out_valid), $sampled(luma_out),
                        $sampled(chroma_out), $sampled(composite_out)));

        a_latency: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                out_valid == v_q[2])
                else flag_error($sformatf("FAIL latency: expected %0b, actual %0b",
                        $sampled(v_q[2]), $sampled(out_valid)));

        a_luma: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                act |-> luma_out == LUMA_CODE[idx3])
                else flag_error($sformatf("FAIL luma_lookup: expected %0d, actual %0d",
                        LUMA_CODE[$sampled(idx3)], $sampled(luma_out)));

        // greys carry no subcarrier
        a_unmod: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                act && AMP_CODE[idx3] == 3'd7 |->
                        chroma_out == '0 && int'(composite_out) == int'(LUMA_CODE[idx3]))
                else flag_error($sformatf("FAIL unmodulated: expected 0 %0d, actual %0d %0d",
                        LUMA_CODE[$sampled(idx3)], $sampled(chroma_out),
                        $sampled(composite_out)));

        a_mod: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                act && AMP_CODE[idx3] != 3'd7 |-> mag_ok(chroma_out, AMP_CODE[idx3]) &&
                        composite_out == comp_ref(LUMA_CODE[idx3], chroma_out))
                else flag_error($sformatf("FAIL modulated: expected |%0d| %0d, actual %0d %0d",
                        `SINE_PEAK >> AMP_CODE[$sampled(idx3)],
                        comp_ref(LUMA_CODE[$sampled(idx3)], $sampled(chroma_out)),
                        $sampled(chroma_out), $sampled(composite_out)));

        a_sync: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                out_valid && kind3 == video_pkg::kind_sync |-> int'(luma_out) == `SYNC_LEVEL &&
                        chroma_out == '0 && int'(composite_out) == `SYNC_LEVEL)
                else flag_error($sformatf("FAIL sync: expected %0d 0 %0d, actual %0d %0d %0d",
                        `SYNC_LEVEL, `SYNC_LEVEL, $sampled(luma_out),
                        $sampled(chroma_out), $sampled(composite_out)));

        a_blank: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                out_valid && kind3 == video_pkg::kind_blank |-> int'(luma_out) == `BLANK_LEVEL &&
                        chroma_out == '0 && int'(composite_out) == `BLANK_LEVEL)
                else flag_error($sformatf("FAIL blank: expected %0d 0 %0d, actual %0d %0d %0d",
                        `BLANK_LEVEL, `BLANK_LEVEL, $sampled(luma_out),
                        $sampled(chroma_out), $sampled(composite_out)));

        // burst sits on the blank pedestal
        a_burst: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                out_valid && kind3 == video_pkg::kind_burst |-> luma_out == LUMA_BLANK &&
                        mag_ok(chroma_out, AMP_BURST) &&
                        composite_out == comp_ref(LUMA_BLANK, chroma_out))
                else flag_error($sformatf("FAIL burst: expected %0d |%0d|, actual %0d %0d %0d",
                        `BLANK_LEVEL, `SINE_PEAK >> AMP_BURST, $sampled(luma_out),
                        $sampled(chroma_out), $sampled(composite_out)));

endmodule

/* sim/composite_encoder_tb.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module composite_encoder_tb;

        localparam int RST_CYC   = 10;
        localparam int SWEEP_LEN = 4 * 16;      // every colour on every chip
        localparam int RUN_LEN   = 4 * 24;      // sync, blank, burst runs per chip
        localparam int RAND_LEN  = 400;
        localparam int MAX_GAP   = 3;
        localparam int DRAIN     = 4;           // pipeline depth plus one
        localparam int TIMEOUT_CYC = RST_CYC + 3 + SWEEP_LEN + RUN_LEN +
                                     RAND_LEN * (MAX_GAP + 1) + DRAIN + 100;

        logic                         clk_dot4x = 1'b0;
        logic                         rst_n;
        logic                         pix_valid;
        palette_pkg::color_index_e    pix_index;
        video_pkg::pixel_kind_e       pix_kind;
        palette_pkg::chip_model_e     chip;
        logic                         out_valid;
        logic [`LUMA_W-1:0]           luma_out;
        logic signed [`CHROMA_W-1:0]  chroma_out;
        logic [`COMP_W-1:0]           composite_out;
        logic [31:0]                  lcg_state = 32'he5ec0b1c;
        int                           cycle_cnt = 0;

        composite_encoder DUT (.*);

        bind composite_encoder composite_encoder_assert u_assert (
                .clk_dot4x     (clk_dot4x),
                .rst_n         (rst_n),
                .pix_valid     (pix_valid),
                .pix_index     (pix_index),
                .pix_kind      (pix_kind),
                .out_valid     (out_valid),
                .luma_out      (luma_out),
                .chroma_out    (chroma_out),
                .composite_out (composite_out)
        );

        always #50 clk_dot4x = ~clk_dot4x;     // 100 ns dot4x period

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // one pixel, held for one clock
        task automatic send_pixel(input logic [3:0] idx, input logic [1:0] kind);
                pix_valid = 1'b1;
                pix_index = palette_pkg::color_index_e'(idx);
                pix_kind  = video_pkg::pixel_kind_e'(kind);
                @(negedge clk_dot4x);
        endtask

        task automatic hold_idle(input int n);
                pix_valid = 1'b0;
                repeat (n) @(negedge clk_dot4x);
        endtask

        always @(posedge clk_dot4x) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= TIMEOUT_CYC) begin
                        $display("Some tests failed");
                        $fatal(1, "timeout, the run did not finish in %0d cycles", TIMEOUT_CYC);
                end
        end

        // any fired assertion ends the run
        always @(negedge clk_dot4x) begin
                if (DUT.u_assert.err_seen) begin
                        $display("Some tests failed");
                        $fatal(1, "an output check did not hold");
                end
        end

        initial begin
                logic [31:0] r;
                logic [1:0]  kind_sel;
                rst_n     = 1'b0;
                pix_valid = 1'b0;
                pix_index = palette_pkg::color_black;
                pix_kind  = video_pkg::kind_sync;
                chip      = palette_pkg::chip_6567r56a;
                repeat (RST_CYC) @(posedge clk_dot4x);
                @(negedge clk_dot4x);
                rst_n = 1'b1;
                hold_idle(2);

                // palette sweep, back to back strobes
                for (int c = 0; c < 4; c++) begin
                        chip = palette_pkg::chip_model_e'(c[1:0]);
                        for (int i = 0; i < 16; i++)
                                send_pixel(i[3:0], video_pkg::kind_active);
                end

                // override runs, index ignored by the mixer
                for (int c = 0; c < 4; c++) begin
                        chip = palette_pkg::chip_model_e'(c[1:0]);
                        for (int i = 0; i < 6; i++)
                                send_pixel(i[3:0], video_pkg::kind_sync);
                        for (int i = 0; i < 6; i++)
                                send_pixel(4'd2, video_pkg::kind_blank);
                        for (int i = 0; i < 10; i++)
                                send_pixel(4'd7, video_pkg::kind_burst);   // burst overrides hue
                        hold_idle(2);
                end

                // random pixels with gaps in the strobe
                for (int n = 0; n < RAND_LEN; n++) begin
                        lcg_state = lcg_next(lcg_state);
                        r = lcg_state;
                        if (n % 50 == 0)
                                chip = palette_pkg::chip_model_e'(r[31:30]);   // quasi-static
                        if (r[29:28] != 2'd3)
                                kind_sel = video_pkg::kind_active;           // three in four
                        else
                                kind_sel = (r[27:26] == 2'd0) ? 2'd1 : r[27:26];
                        send_pixel(r[23:20], kind_sel);
                        hold_idle(int'(r[17:16]));
                end

                hold_idle(DRAIN);
                if (DUT.u_assert.err_seen) begin
                        $display("Some tests failed");
                        $fatal(1, "an output check did not hold");
                end else begin
                        $display("All tests passed");
                        $finish;
                end
        end

endmodule
